// File: common/histPkg.sv
package histPkg;

    // photon timestamp width
    localparam int Np = 10;

    // timestamp msbs used as the bin index
    localparam int BIN_BITS = 6;
    localparam int BIN_NUM = 1 << BIN_BITS;

    // bin counters saturate at all ones
    localparam int COUNT_W = 8;

    // frame counter width, wraps
    localparam int FRAME_W = 8;

    typedef logic [Np-1:0] timestampT;
    typedef logic [BIN_BITS-1:0] binT;
    typedef logic [COUNT_W-1:0] countT;

    localparam countT COUNT_MAX = '1;

    // peak of one pixel, bin in the upper field
    typedef struct packed {
        binT bin;
        countT count;
    } peakT;

    // index width for a counter over n items, never zero
    function automatic int cntW(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // word address width of the shared count ram
    function automatic int addrW(input int pixelNum);
        return $clog2(pixelNum * BIN_NUM);
    endfunction

endpackage

// File: common/sifhRegPkg.sv
package sifhRegPkg;

    // wishbone data width and word address width
    localparam int WB_DW = 32;
    localparam int WB_AW = 4;

    // register map, word offsets
    localparam logic [WB_AW-1:0] REG_STATUS = 4'd0;
    localparam logic [WB_AW-1:0] REG_PEAK_BASE = 4'd1;

    // status fields
    localparam int STAT_DONE_BIT = 0;
    localparam int STAT_READY_BIT = 1;
    localparam int STAT_FRAME_LSB = 8;

    // peak register fields
    localparam int PEAK_BIN_LSB = 0;
    localparam int PEAK_COUNT_LSB = 8;

endpackage

// File: histogram/countRam.sv
`timescale 1ns/1ps

module countRam import histPkg::*; #(
    parameter int DEPTH = 192,
    localparam int AW = $clog2(DEPTH)
) (
    input logic clk,
    input logic wrEn,
    input logic [AW-1:0] wrAddr,
    input countT wrData,
    input logic rdEn,
    input logic [AW-1:0] rdAddr,
    output countT rdData
);

    // one region of BIN_NUM words per pixel
    countT mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// File: histogram/binAccumulator.sv
`timescale 1ns/1ps

module binAccumulator import histPkg::*; #(
    parameter int PIXEL_NUM = 3,
    localparam int PW = cntW(PIXEL_NUM),
    localparam int ADDR_W = addrW(PIXEL_NUM)
) (
    input logic clk,
    input logic reset,
    input logic sampleValid,
    input logic [PW-1:0] pixel,
    input timestampT sample,
    input countT rdData,
    output logic rdEn,
    output logic [ADDR_W-1:0] rdAddr,
    output logic wrEn,
    output logic [ADDR_W-1:0] wrAddr,
    output countT wrData
);

    logic [ADDR_W-1:0] inAddr;

    // valid bit per stage
    logic s1Valid;
    logic s2Valid;
    logic s3Valid;

    // address and count carried down the pipe
    logic [ADDR_W-1:0] s1Addr;
    logic [ADDR_W-1:0] s2Addr;
    logic [ADDR_W-1:0] s3Addr;
    countT s2Count;
    countT s3Count;

    countT curCount;
    countT nextCount;

    // pixel region base plus bin from the timestamp msbs
    assign inAddr = ADDR_W'({pixel, sample[Np-1 -: BIN_BITS]});

    // stage 1 read issued in the accept cycle
    assign rdEn = sampleValid;
    assign rdAddr = inAddr;

    // ram data can be stale by up to two writes
    always_comb begin
        if (s2Valid && s2Addr == s1Addr) begin
            // write going out this cycle is the newest
            curCount = s2Count;
        end else if (s3Valid && s3Addr == s1Addr) begin
            // written last cycle so our read missed it
            curCount = s3Count;
        end else begin
            curCount = rdData;
        end
    end

    // saturating increment
    assign nextCount = (curCount == COUNT_MAX) ? curCount : curCount + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= sampleValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= inAddr;
        s2Addr <= s1Addr;
        s2Count <= nextCount;
        // copy of the last write for forwarding
        s3Addr <= s2Addr;
        s3Count <= s2Count;
    end

    // stage 2 drives the write port
    assign wrEn = s2Valid;
    assign wrAddr = s2Addr;
    assign wrData = s2Count;

    // no write to an unknown address
    wrAddrKnown: assert property (@(posedge clk) disable iff (reset)
        wrEn |-> !$isunknown(wrAddr));

endmodule

// File: histogram/peakSearch.sv
`timescale 1ns/1ps

module peakSearch import histPkg::*; #(
    parameter int PIXEL_NUM = 3,
    localparam int PW = cntW(PIXEL_NUM),
    localparam int ADDR_W = addrW(PIXEL_NUM)
) (
    input logic clk,
    input logic reset,
    input logic start,
    input countT rdData,
    output logic rdEn,
    output logic [ADDR_W-1:0] rdAddr,
    output logic wrEn,
    output logic [ADDR_W-1:0] wrAddr,
    output countT wrData,
    output logic peakValid,
    output logic [PW-1:0] peakPixel,
    output peakT peakValue,
    output logic busy
);

    logic [PW-1:0] pixCnt;
    // 0..BIN_NUM-1 read, BIN_NUM last compare, BIN_NUM+1 emit
    logic [BIN_BITS:0] step;
    logic rdPend;
    binT rdBin;
    logic [ADDR_W-1:0] rdPendAddr;
    countT maxCount;
    binT maxBin;
    logic lastPixel;

    assign lastPixel = pixCnt == PW'(PIXEL_NUM - 1);

    // reads only while the step is below BIN_NUM
    assign rdEn = busy && !step[BIN_BITS];
    assign rdAddr = ADDR_W'({pixCnt, step[BIN_BITS-1:0]});

    // clear behind the read, one cycle later
    assign wrEn = rdPend;
    assign wrAddr = rdPendAddr;
    assign wrData = '0;

    assign peakValid = busy && step == (BIN_BITS + 1)'(BIN_NUM + 1);
    assign peakPixel = pixCnt;
    assign peakValue = {maxBin, maxCount};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            rdPend <= 1'b0;
            pixCnt <= '0;
            step <= '0;
        end else begin
            rdPend <= rdEn;
            if (start) begin
                busy <= 1'b1;
                pixCnt <= '0;
                step <= '0;
            end else if (busy) begin
                if (peakValid) begin
                    // next pixel, or done after the last one
                    step <= '0;
                    pixCnt <= pixCnt + 1'b1;
                    if (lastPixel) begin
                        busy <= 1'b0;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rdBin <= step[BIN_BITS-1:0];
        rdPendAddr <= rdAddr;
        if (start || peakValid) begin
            maxCount <= '0;
            maxBin <= '0;
        end else if (rdPend && rdData > maxCount) begin
            // strictly greater, so the lowest bin keeps a tie
            maxCount <= rdData;
            maxBin <= rdBin;
        end
    end

    // builder must wait for the sweep to end
    startWhileBusy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

// File: histogram/histBuilder.sv
`timescale 1ns/1ps

module histBuilder import histPkg::*; #(
    parameter int PIXEL_NUM = 3,
    parameter int ACQ_NUM = 2,
    parameter int DATA_NUM = 2
) (
    input logic clk,
    input logic reset,
    input logic wrEn,
    input timestampT data,
    output logic ready,
    output logic done,
    output logic [FRAME_W-1:0] frameCount,
    output peakT peaks [PIXEL_NUM]
);

    localparam int DEPTH = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W = addrW(PIXEL_NUM);
    localparam int PW = cntW(PIXEL_NUM);
    localparam int QW = cntW(ACQ_NUM);
    localparam int DW = cntW(DATA_NUM);

    typedef enum logic [1:0] {stClear, stAcquire, stDrain, stSearch} stateT;

    stateT state;
    logic [ADDR_W-1:0] clrAddr;
    logic drainCnt;
    logic start;
    logic accept;
    logic frameEnd;
    logic lastPeak;

    // sample position inside the frame
    logic [DW-1:0] dataIdx;
    logic [PW-1:0] pixIdx;
    logic [QW-1:0] acqIdx;
    logic lastData;
    logic lastPix;
    logic lastAcq;

    // accumulator side of the ram
    logic accRdEn;
    logic accWrEn;
    logic [ADDR_W-1:0] accRdAddr;
    logic [ADDR_W-1:0] accWrAddr;
    countT accWrData;

    // search side of the ram
    logic srchRdEn;
    logic srchWrEn;
    logic [ADDR_W-1:0] srchRdAddr;
    logic [ADDR_W-1:0] srchWrAddr;
    countT srchWrData;
    logic peakValid;
    logic [PW-1:0] peakPixel;
    peakT peakValue;
    logic busy;

    // shared ram ports
    logic ramRdEn;
    logic ramWrEn;
    logic [ADDR_W-1:0] ramRdAddr;
    logic [ADDR_W-1:0] ramWrAddr;
    countT ramRdData;
    countT ramWrData;

    assign ready = state == stAcquire;
    assign accept = wrEn && ready;

    assign lastData = dataIdx == DW'(DATA_NUM - 1);
    assign lastPix = pixIdx == PW'(PIXEL_NUM - 1);
    assign lastAcq = acqIdx == QW'(ACQ_NUM - 1);
    assign frameEnd = accept && lastData && lastPix && lastAcq;

    // second drain cycle, last accumulator write is going out
    assign start = state == stDrain && drainCnt;
    assign lastPeak = peakValid && peakPixel == PW'(PIXEL_NUM - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stClear;
            clrAddr <= '0;
            drainCnt <= 1'b0;
            done <= 1'b0;
            frameCount <= '0;
        end else begin
            case (state)
                stClear: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == ADDR_W'(DEPTH - 1)) begin
                        state <= stAcquire;
                    end
                end
                stAcquire: begin
                    if (frameEnd) begin
                        state <= stDrain;
                        drainCnt <= 1'b0;
                    end
                end
                stDrain: begin
                    drainCnt <= 1'b1;
                    if (start) begin
                        state <= stSearch;
                    end
                end
                stSearch: begin
                    // ready and done rise with the last stored peak
                    if (lastPeak) begin
                        state <= stAcquire;
                        done <= 1'b1;
                        frameCount <= frameCount + 1'b1;
                    end
                end
                default: state <= stClear;
            endcase
            if (accept) begin
                done <= 1'b0;
            end
        end
    end

    // order is acquisition, pixel, sample
    always_ff @(posedge clk) begin
        if (reset) begin
            dataIdx <= '0;
            pixIdx <= '0;
            acqIdx <= '0;
        end else if (accept) begin
            dataIdx <= lastData ? '0 : dataIdx + 1'b1;
            if (lastData) begin
                pixIdx <= lastPix ? '0 : pixIdx + 1'b1;
                if (lastPix) begin
                    acqIdx <= lastAcq ? '0 : acqIdx + 1'b1;
                end
            end
        end
    end

    // peak registers, visible over the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                peaks[p] <= '0;
            end
        end else if (peakValid) begin
            peaks[peakPixel] <= peakValue;
        end
    end

    // ram port owner: clear sweep, search, else accumulator
    always_comb begin
        if (state == stClear) begin
            ramWrEn = 1'b1;
            ramWrAddr = clrAddr;
            ramWrData = '0;
        end else if (busy) begin
            ramWrEn = srchWrEn;
            ramWrAddr = srchWrAddr;
            ramWrData = srchWrData;
        end else begin
            ramWrEn = accWrEn;
            ramWrAddr = accWrAddr;
            ramWrData = accWrData;
        end
        ramRdEn = busy ? srchRdEn : accRdEn;
        ramRdAddr = busy ? srchRdAddr : accRdAddr;
    end

    countRam #(
        .DEPTH(DEPTH)
    ) countRam_inst (
        .clk(clk),
        .wrEn(ramWrEn),
        .wrAddr(ramWrAddr),
        .wrData(ramWrData),
        .rdEn(ramRdEn),
        .rdAddr(ramRdAddr),
        .rdData(ramRdData)
    );

    binAccumulator #(
        .PIXEL_NUM(PIXEL_NUM)
    ) binAccumulator_inst (
        .clk(clk),
        .reset(reset),
        .sampleValid(accept),
        .pixel(pixIdx),
        .sample(data),
        .rdData(ramRdData),
        .rdEn(accRdEn),
        .rdAddr(accRdAddr),
        .wrEn(accWrEn),
        .wrAddr(accWrAddr),
        .wrData(accWrData)
    );

    peakSearch #(
        .PIXEL_NUM(PIXEL_NUM)
    ) peakSearch_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .rdData(ramRdData),
        .rdEn(srchRdEn),
        .rdAddr(srchRdAddr),
        .wrEn(srchWrEn),
        .wrAddr(srchWrAddr),
        .wrData(srchWrData),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakValue(peakValue),
        .busy(busy)
    );

endmodule

// File: hdl/sifhRegs.sv
`timescale 1ns/1ps

module sifhRegs import histPkg::*, sifhRegPkg::*; #(
    parameter int PIXEL_NUM = 3
) (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [WB_AW-1:0] adr,
    input logic [WB_DW-1:0] datWr,
    input logic done,
    input logic ready,
    input logic [FRAME_W-1:0] frameCount,
    input peakT peaks [PIXEL_NUM],
    output logic ack,
    output logic [WB_DW-1:0] datRd
);

    logic access;
    logic [WB_DW-1:0] rdWord;

    // new cycle only when ack is low, so ack is one cycle wide
    assign access = cyc && stb && !ack;

    // address decode, unmapped words read zero
    always_comb begin
        rdWord = '0;
        if (adr == REG_STATUS) begin
            rdWord[STAT_DONE_BIT] = done;
            rdWord[STAT_READY_BIT] = ready;
            rdWord[STAT_FRAME_LSB +: FRAME_W] = frameCount;
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (adr == WB_AW'(REG_PEAK_BASE + p)) begin
                rdWord[PEAK_BIN_LSB +: BIN_BITS] = peaks[p].bin;
                rdWord[PEAK_COUNT_LSB +: COUNT_W] = peaks[p].count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (access) begin
            // no writable registers, writes just get acked
            datRd <= we ? '0 : rdWord;
        end
    end

    ackOneCycle: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack);

    // master holds write data for the whole access
    wrDataStable: assert property (@(posedge clk) disable iff (reset)
        access && we |=> $stable(datWr) && !$isunknown(datWr));

endmodule

// File: hdl/sifhTop.sv
`timescale 1ns/1ps

module sifhTop import histPkg::*, sifhRegPkg::*; #(
    parameter int PIXEL_NUM = 3,
    parameter int ACQ_NUM = 2,
    parameter int DATA_NUM = 2
) (
    input logic clk,
    input logic reset,
    // photon timestamp stream
    input logic wrEn,
    input timestampT data,
    output logic ready,
    // wishbone slave
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [WB_AW-1:0] adr,
    input logic [WB_DW-1:0] datWr,
    output logic ack,
    output logic [WB_DW-1:0] datRd
);

    logic done;
    logic [FRAME_W-1:0] frameCount;
    peakT peaks [PIXEL_NUM];

    histBuilder #(
        .PIXEL_NUM(PIXEL_NUM),
        .ACQ_NUM(ACQ_NUM),
        .DATA_NUM(DATA_NUM)
    ) histBuilder_inst (
        .clk(clk),
        .reset(reset),
        .wrEn(wrEn),
        .data(data),
        .ready(ready),
        .done(done),
        .frameCount(frameCount),
        .peaks(peaks)
    );

    sifhRegs #(
        .PIXEL_NUM(PIXEL_NUM)
    ) sifhRegs_inst (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datWr(datWr),
        .done(done),
        .ready(ready),
        .frameCount(frameCount),
        .peaks(peaks),
        .ack(ack),
        .datRd(datRd)
    );

endmodule

// File: sim/sifhTb.sv
`timescale 1ns/1ps

module sifhTb import histPkg::*, sifhRegPkg::*; ();

    localparam int PIXEL_NUM = 3;
    localparam int ACQ_NUM = 2;
    localparam int DATA_NUM = 2;
    localparam int FRAME_LEN = PIXEL_NUM * ACQ_NUM * DATA_NUM;
    localparam int TABLE_FRAMES = 4;
    // table frames, two random frames, one frame ahead of the stray samples
    localparam int NUM_FRAMES = TABLE_FRAMES + 3;
    localparam int SEARCH_LEN = PIXEL_NUM * (BIN_NUM + 2);
    localparam int CLEAR_LEN = PIXEL_NUM * BIN_NUM;
    localparam int CYCLE_LIMIT = 8 * (NUM_FRAMES * (FRAME_LEN + SEARCH_LEN) + CLEAR_LEN);
    localparam int STRAY_CYCLES = 20;

    logic clk = 1'b0;
    logic reset;
    logic wrEn;
    timestampT data;
    logic ready;
    logic cyc;
    logic stb;
    logic we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] datWr;
    logic ack;
    logic [WB_DW-1:0] datRd;

    // stimulus rows and the peak words worked out by hand, count in the upper byte
    timestampT stimTable [TABLE_FRAMES][FRAME_LEN];
    logic [15:0] expTable [TABLE_FRAMES][PIXEL_NUM];
    string testNames [TABLE_FRAMES];

    timestampT frameBuf [FRAME_LEN];
    logic [WB_DW-1:0] expPeak [PIXEL_NUM];
    int unsigned lcgState = 75;
    int errCount = 0;
    int testCount = 0;
    int expFrames = 0;
    int cycleCount = 0;

    always #10 clk = ~clk;

    sifhTop #(
        .PIXEL_NUM(PIXEL_NUM),
        .ACQ_NUM(ACQ_NUM),
        .DATA_NUM(DATA_NUM)
    ) sifhTop_inst (
        .clk(clk),
        .reset(reset),
        .wrEn(wrEn),
        .data(data),
        .ready(ready),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .datWr(datWr),
        .ack(ack),
        .datRd(datRd)
    );

    // hard stop if anything stalls
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // sample order per pixel: acq 0 gives slots 2p, 2p+1, acq 1 gives 6+2p, 7+2p
    task automatic loadTable();
        stimTable[0] = '{10'd83, 10'd95, 10'd529, 10'd328, 10'd1023, 10'd2,
                         10'd80, 10'd148, 10'd537, 10'd112, 10'd1008, 10'd1015};
        expTable[0] = '{16'h0305, 16'h0221, 16'h033f};
        testNames[0] = "table frame";
        // pixel 0 hits bin 42 on back-to-back samples
        stimTable[1] = '{10'd672, 10'd673, 10'd160, 10'd170, 10'd16, 10'd31,
                         10'd680, 10'd687, 10'd175, 10'd180, 10'd20, 10'd25};
        expTable[1] = '{16'h042a, 16'h030a, 16'h0401};
        testNames[1] = "same bin forwarding";
        // every pixel has two bins at count 2
        stimTable[2] = '{10'd800, 10'd49, 10'd640, 10'd192, 10'd4, 10'd1023,
                         10'd57, 10'd805, 10'd655, 10'd195, 10'd1017, 10'd9};
        expTable[2] = '{16'h0203, 16'h020c, 16'h0200};
        testNames[2] = "bin tie";
        stimTable[3] = '{10'd272, 10'd279, 10'd400, 10'd960, 10'd128, 10'd144,
                         10'd33, 10'd285, 10'd970, 10'd976, 10'd150, 10'd159};
        expTable[3] = '{16'h0311, 16'h023c, 16'h0309};
        testNames[3] = "stray samples";
    endtask

    function automatic int unsigned lcgNext(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic logFailure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errCount++;
    endtask

    task automatic finishTest(input string name, input int errsAtStart);
        testCount++;
        $display("test %0d %s: %s", testCount, name, errCount == errsAtStart ? "ok" : "failed");
    endtask

    task automatic loadFrame(input int row);
        for (int i = 0; i < FRAME_LEN; i++) begin
            frameBuf[i] = stimTable[row][i];
        end
    endtask

    task automatic randomFrame();
        for (int i = 0; i < FRAME_LEN; i++) begin
            lcgState = lcgNext(lcgState);
            frameBuf[i] = Np'(lcgState >> 16);
        end
    endtask

    // histograms start empty, lowest bin keeps a tie, counts stop at all ones
    task automatic computeModel();
        int cnt [PIXEL_NUM][BIN_NUM];
        int pix;
        int bin;
        int best;
        int bestBin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                cnt[p][b] = 0;
            end
        end
        for (int i = 0; i < FRAME_LEN; i++) begin
            pix = (i / DATA_NUM) % PIXEL_NUM;
            bin = int'(frameBuf[i]) >> (Np - BIN_BITS);
            if (cnt[pix][bin] < (1 << COUNT_W) - 1) begin
                cnt[pix][bin]++;
            end
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best = 0;
            bestBin = 0;
            for (int b = 0; b < BIN_NUM; b++) begin
                if (cnt[p][b] > best) begin
                    best = cnt[p][b];
                    bestBin = b;
                end
            end
            expPeak[p] = WB_DW'((best << PEAK_COUNT_LSB) | (bestBin << PEAK_BIN_LSB));
        end
    endtask

    task automatic checkTable(input int row);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (expPeak[p] !== WB_DW'(expTable[row][p])) begin
                logFailure($sformatf("model peak %h for pixel %0d, table says %h",
                    expPeak[p], p, expTable[row][p]));
            end
        end
    endtask

    task automatic wbRead(input logic [WB_AW-1:0] addr, output logic [WB_DW-1:0] word);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        word = datRd;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wbWrite(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] word);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = addr;
        datWr = word;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    // one sample per cycle while ready is up
    task automatic sendFrame();
        int i;
        i = 0;
        while (i < FRAME_LEN) begin
            @(posedge clk);
            #1;
            wrEn = ready;
            if (ready) begin
                data = frameBuf[i];
                i++;
            end
        end
        @(posedge clk);
        #1;
        wrEn = 1'b0;
    endtask

    task automatic driveStray();
        repeat (STRAY_CYCLES) begin
            @(posedge clk);
            #1;
            if (ready) begin
                logFailure("ready high while stray samples are driven");
            end
            wrEn = 1'b1;
            data = 10'd272;
        end
        @(posedge clk);
        #1;
        wrEn = 1'b0;
    endtask

    // poll status, done and ready come up together
    task automatic awaitDone();
        logic [WB_DW-1:0] word;
        do begin
            wbRead(REG_STATUS, word);
        end while (!word[STAT_DONE_BIT]);
        expFrames++;
        if (word[STAT_FRAME_LSB +: FRAME_W] !== FRAME_W'(expFrames)) begin
            logFailure($sformatf("frame count %0d, expected %0d",
                word[STAT_FRAME_LSB +: FRAME_W], expFrames));
        end
        if (!word[STAT_READY_BIT]) begin
            logFailure("ready low while done is set");
        end
    endtask

    task automatic checkPeaks();
        logic [WB_DW-1:0] word;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            wbRead(WB_AW'(REG_PEAK_BASE + p), word);
            if (word !== expPeak[p]) begin
                logFailure($sformatf("pixel %0d peak %h, expected %h", p, word, expPeak[p]));
            end
        end
    endtask

    initial begin
        int errsAtStart;
        int startFrames;
        logic [WB_DW-1:0] word;
        reset = 1'b1;
        wrEn = 1'b0;
        data = '0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datWr = '0;
        loadTable();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // clear sweep runs with ready low
        while (!ready) begin
            @(posedge clk);
            #1;
        end

        errsAtStart = errCount;
        wbRead(REG_STATUS, word);
        if (word !== WB_DW'(1 << STAT_READY_BIT)) begin
            logFailure($sformatf("status %h after reset", word));
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expPeak[p] = '0;
        end
        checkPeaks();
        // writes are acked and change nothing
        wbWrite(REG_STATUS, '1);
        wbRead(REG_STATUS, word);
        if (word !== WB_DW'(1 << STAT_READY_BIT)) begin
            logFailure($sformatf("status %h after a write", word));
        end
        finishTest("reset state", errsAtStart);

        for (int t = 0; t < TABLE_FRAMES - 1; t++) begin
            errsAtStart = errCount;
            loadFrame(t);
            computeModel();
            checkTable(t);
            sendFrame();
            awaitDone();
            checkPeaks();
            finishTest(testNames[t], errsAtStart);
        end

        // two random frames, second one checked against an empty start
        errsAtStart = errCount;
        startFrames = expFrames;
        randomFrame();
        sendFrame();
        awaitDone();
        randomFrame();
        computeModel();
        sendFrame();
        awaitDone();
        checkPeaks();
        wbRead(REG_STATUS, word);
        if (word[STAT_FRAME_LSB +: FRAME_W] !== FRAME_W'(startFrames + 2)) begin
            logFailure($sformatf("frame count %0d after two random frames",
                word[STAT_FRAME_LSB +: FRAME_W]));
        end
        finishTest("random frames", errsAtStart);

        // stray samples during drain and search must be dropped
        errsAtStart = errCount;
        loadFrame(0);
        sendFrame();
        driveStray();
        awaitDone();
        loadFrame(TABLE_FRAMES - 1);
        computeModel();
        checkTable(TABLE_FRAMES - 1);
        sendFrame();
        awaitDone();
        checkPeaks();
        wbRead(4'hf, word);
        if (word !== '0) begin
            logFailure($sformatf("unmapped address reads %h", word));
        end
        finishTest(testNames[TABLE_FRAMES - 1], errsAtStart);

        $display("tests run: %0d, failed checks: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
common/histPkg.sv
common/sifhRegPkg.sv
histogram/countRam.sv
histogram/binAccumulator.sv
histogram/peakSearch.sv
histogram/histBuilder.sv
hdl/sifhRegs.sv
hdl/sifhTop.sv
sim/sifhTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module sifhTb -f filelist.f -o sifhSim \
    && ./obj_dir/sifhSim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
